/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int xlen = 64;
  localparam logic [xlen-1:0] reset_vector = 64'h0000_0000_8000_0000;
  localparam int dmem_words = 128;
  // data memory sits one page above the reset vector
  localparam logic [xlen-1:0] dmem_base = reset_vector + 64'h1000;

  // major opcode field, inst[6:0]
  typedef enum logic [6:0] {
    opc_load      = 7'b0000011,
    opc_op_imm    = 7'b0010011,
    opc_auipc     = 7'b0010111,
    opc_op_imm_32 = 7'b0011011,
    opc_store     = 7'b0100011,
    opc_op        = 7'b0110011,
    opc_lui       = 7'b0110111,
    opc_branch    = 7'b1100011,
    opc_jalr      = 7'b1100111,
    opc_jal       = 7'b1101111,
    opc_system    = 7'b1110011
  } opcode_e;

  typedef enum logic [4:0] {
    op_add, op_sub, op_addi, op_addiw, op_slli, op_sltiu, op_andi, op_xori,
    op_lui, op_auipc,
    op_jal, op_jalr,
    op_beq, op_bne,
    op_lw, op_lbu, op_ld,
    op_sb, op_sh, op_sd,
    op_ebreak,
    op_illegal
  } op_e;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_sltu, alu_xor, alu_and, alu_sll, alu_addw
  } alu_op_e;

  typedef struct packed {
    op_e             op;
    alu_op_e         alu_op;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] imm;
    logic            use_imm;
    logic            use_pc;
    logic            writes_rd;
  } decoded_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [4:0]      rd;
    logic            we;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] next_pc;
  } retire_t;

endpackage

`default_nettype wire

/* rv_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  alu_op_e         alu_op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] y,
  output logic            zero
);

  logic [xlen-1:0] sum;
  logic [xlen-1:0] diff;

  assign sum = a + b;
  assign diff = a - b;

  always_comb begin
    case (alu_op)
      alu_add:  y = sum;
      alu_sub:  y = diff;
      alu_sltu: y = {{(xlen-1){1'b0}}, a < b};
      alu_xor:  y = a ^ b;
      alu_and:  y = a & b;
      alu_sll:  y = a << b[5:0];
      // low word only, sign extension happens in the execute unit
      alu_addw: y = {32'b0, sum[31:0]};
      default:  y = sum;
    endcase
  end

  // branch equality through a - b
  assign zero = (y == '0);

endmodule

`default_nettype wire

/* rv_lsu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_lsu import rv_pkg::*; (
  input  logic            clk,
  input  op_e             op,
  input  logic [xlen-1:0] addr,
  input  logic [xlen-1:0] store_data,
  input  logic            store_en,
  output logic [xlen-1:0] load_data
);

  logic [xlen-1:0] mem [dmem_words];

  logic [xlen-1:0] offset;
  logic            in_range;
  logic [6:0]      idx;
  logic [7:0]      byte_mask;
  logic [xlen-1:0] lane_data;
  logic [xlen-1:0] word;
  logic [xlen-1:0] shifted;
  logic [31:0]     half;

  assign offset = addr - dmem_base;
  assign in_range = offset < dmem_words * 8;
  assign idx = addr[9:3];

  // byte lanes and replicated data per store width
  always_comb begin
    byte_mask = 8'h00;
    lane_data = store_data;
    case (op)
      op_sb: begin
        byte_mask = 8'b0000_0001 << addr[2:0];
        lane_data = {8{store_data[7:0]}};
      end
      op_sh: begin
        byte_mask = 8'b0000_0011 << {addr[2:1], 1'b0};
        lane_data = {4{store_data[15:0]}};
      end
      op_sd: begin
        byte_mask = 8'hff;
      end
      default: begin
        byte_mask = 8'h00;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (store_en && in_range) begin
      for (int i = 0; i < 8; i++) begin
        if (byte_mask[i]) begin
          mem[idx][8*i +: 8] <= lane_data[8*i +: 8];
        end
      end
    end
  end

  // out of range reads as zero
  assign word = in_range ? mem[idx] : '0;
  assign shifted = word >> {addr[2:0], 3'b000};
  assign half = addr[2] ? word[63:32] : word[31:0];

  always_comb begin
    case (op)
      op_lw:   load_data = {{32{half[31]}}, half};
      op_lbu:  load_data = {56'b0, shifted[7:0]};
      op_ld:   load_data = word;
      default: load_data = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            we,
  input  logic [4:0]      waddr,
  input  logic [xlen-1:0] wdata,
  input  logic [4:0]      raddr1,
  input  logic [4:0]      raddr2,
  output logic [xlen-1:0] rdata1,
  output logic [xlen-1:0] rdata2,
  output logic            a0_nonzero
);

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

  // x10 port, exit status at ebreak
  assign a0_nonzero = |regs[10];

endmodule

`default_nettype wire

/* rv_idu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_idu import rv_pkg::*; (
  input  logic [31:0] inst,
  output decoded_t    dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec.op = op_illegal;
    dec.alu_op = alu_add;
    dec.rd = inst[11:7];
    dec.rs1 = inst[19:15];
    dec.rs2 = inst[24:20];
    dec.imm = imm_i;
    dec.use_imm = 1'b0;
    dec.use_pc = 1'b0;
    dec.writes_rd = 1'b0;
    case (opcode)
      opc_op: begin
        dec.writes_rd = 1'b1;
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          dec.op = op_add;
        end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
          dec.op = op_sub;
          dec.alu_op = alu_sub;
        end else begin
          dec.writes_rd = 1'b0;
        end
      end
      opc_op_imm: begin
        dec.writes_rd = 1'b1;
        dec.use_imm = 1'b1;
        case (funct3)
          3'b000: dec.op = op_addi;
          3'b011: begin
            dec.op = op_sltiu;
            dec.alu_op = alu_sltu;
          end
          3'b100: begin
            dec.op = op_xori;
            dec.alu_op = alu_xor;
          end
          3'b111: begin
            dec.op = op_andi;
            dec.alu_op = alu_and;
          end
          3'b001: begin
            // rv64 slli keeps a 6 bit shamt, top six bits must be zero
            if (inst[31:26] == 6'b0) begin
              dec.op = op_slli;
              dec.alu_op = alu_sll;
            end else begin
              dec.writes_rd = 1'b0;
            end
          end
          default: dec.writes_rd = 1'b0;
        endcase
      end
      opc_op_imm_32: begin
        if (funct3 == 3'b000) begin
          dec.op = op_addiw;
          dec.alu_op = alu_addw;
          dec.use_imm = 1'b1;
          dec.writes_rd = 1'b1;
        end
      end
      opc_lui: begin
        dec.op = op_lui;
        dec.imm = imm_u;
        dec.writes_rd = 1'b1;
      end
      opc_auipc: begin
        dec.op = op_auipc;
        dec.imm = imm_u;
        dec.use_pc = 1'b1;
        dec.use_imm = 1'b1;
        dec.writes_rd = 1'b1;
      end
      opc_jal: begin
        dec.op = op_jal;
        dec.imm = imm_j;
        dec.use_pc = 1'b1;
        dec.use_imm = 1'b1;
        dec.writes_rd = 1'b1;
      end
      opc_jalr: begin
        if (funct3 == 3'b000) begin
          dec.op = op_jalr;
          dec.use_imm = 1'b1;
          dec.writes_rd = 1'b1;
        end
      end
      opc_branch: begin
        // compare through subtraction of rs1 and rs2
        dec.imm = imm_b;
        dec.alu_op = alu_sub;
        if (funct3 == 3'b000) begin
          dec.op = op_beq;
        end else if (funct3 == 3'b001) begin
          dec.op = op_bne;
        end
      end
      opc_load: begin
        dec.use_imm = 1'b1;
        dec.writes_rd = 1'b1;
        case (funct3)
          3'b010: dec.op = op_lw;
          3'b100: dec.op = op_lbu;
          3'b011: dec.op = op_ld;
          default: dec.writes_rd = 1'b0;
        endcase
      end
      opc_store: begin
        dec.imm = imm_s;
        dec.use_imm = 1'b1;
        case (funct3)
          3'b000: dec.op = op_sb;
          3'b001: dec.op = op_sh;
          3'b011: dec.op = op_sd;
          default: dec.op = op_illegal;
        endcase
      end
      opc_system: begin
        if (inst == 32'h0010_0073) begin
          dec.op = op_ebreak;
        end
      end
      default: dec.op = op_illegal;
    endcase
  end

endmodule

`default_nettype wire

/* rv_exu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_exu import rv_pkg::*; (
  input  logic            clk,
  input  decoded_t        dec,
  input  logic [xlen-1:0] src1,
  input  logic [xlen-1:0] src2,
  input  logic [xlen-1:0] pc,
  input  logic            run,
  output logic            we,
  output logic [xlen-1:0] wdata,
  output logic [xlen-1:0] next_pc,
  output logic            is_ebreak
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_y;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] branch_target;
  logic            alu_zero;
  logic            is_store;

  assign op_a = dec.use_pc ? pc : src1;

  always_comb begin
    if (dec.use_imm) begin
      op_b = dec.imm;
    end else begin
      op_b = src2;
    end
  end

  rv_alu i_rv_alu (
    .alu_op (dec.alu_op),
    .a      (op_a),
    .b      (op_b),
    .y      (alu_y),
    .zero   (alu_zero)
  );

  assign alu_res = (dec.op == op_addiw) ? {{32{alu_y[31]}}, alu_y[31:0]} : alu_y;

  assign is_store = (dec.op == op_sb) || (dec.op == op_sh) || (dec.op == op_sd);

  rv_lsu i_rv_lsu (
    .clk        (clk),
    .op         (dec.op),
    .addr       (alu_y),
    .store_data (src2),
    .store_en   (run && is_store),
    .load_data  (load_data)
  );

  assign pc_plus4 = pc + 64'd4;
  assign branch_target = pc + dec.imm;

  always_comb begin
    case (dec.op)
      op_lui:                    wdata = dec.imm;
      op_jal, op_jalr:           wdata = pc_plus4;
      op_lw, op_lbu, op_ld:      wdata = load_data;
      default:                   wdata = alu_res;
    endcase
  end

  assign we = run && dec.writes_rd && (dec.rd != 5'd0);

  always_comb begin
    case (dec.op)
      op_jal:  next_pc = alu_y;
      op_jalr: next_pc = {alu_y[xlen-1:1], 1'b0};
      op_beq:  next_pc = alu_zero ? branch_target : pc_plus4;
      op_bne:  next_pc = alu_zero ? pc_plus4 : branch_target;
      default: next_pc = pc_plus4;
    endcase
  end

  // an illegal word stops the core like ebreak
  assign is_ebreak = (dec.op == op_ebreak) || (dec.op == op_illegal);

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [31:0]     inst,
  output logic [xlen-1:0] pc,
  output retire_t         retire,
  output logic            halt,
  output logic            exit_code
);

  decoded_t        dec;
  logic [xlen-1:0] src1;
  logic [xlen-1:0] src2;
  logic [xlen-1:0] wdata;
  logic [xlen-1:0] next_pc;
  logic            we;
  logic            is_ebreak;
  logic            a0_nonzero;
  logic            run;

  assign run = rst_n && !halt;

  rv_idu i_rv_idu (
    .inst (inst),
    .dec  (dec)
  );

  rv_regfile i_rv_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .we         (we),
    .waddr      (dec.rd),
    .wdata      (wdata),
    .raddr1     (dec.rs1),
    .raddr2     (dec.rs2),
    .rdata1     (src1),
    .rdata2     (src2),
    .a0_nonzero (a0_nonzero)
  );

  rv_exu i_rv_exu (
    .clk       (clk),
    .dec       (dec),
    .src1      (src1),
    .src2      (src2),
    .pc        (pc),
    .run       (run),
    .we        (we),
    .wdata     (wdata),
    .next_pc   (next_pc),
    .is_ebreak (is_ebreak)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_vector;
      halt <= 1'b0;
      exit_code <= 1'b0;
    end else if (!halt) begin
      if (is_ebreak) begin
        // pc holds on the halting instruction
        halt <= 1'b1;
        exit_code <= a0_nonzero || (dec.op == op_illegal);
      end else begin
        pc <= next_pc;
      end
    end
  end

  always_comb begin
    retire.valid = run;
    retire.pc = pc;
    retire.rd = dec.rd;
    retire.we = we;
    retire.wdata = wdata;
    retire.next_pc = next_pc;
  end

endmodule

`default_nettype wire

/* tb_core_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_chk import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [xlen-1:0] pc,
  input  retire_t         retire,
  input  logic            halt
);

  int n_fail = 0;

  a_no_retire_halted: assert property (
    @(posedge clk) disable iff (!rst_n) halt |-> !retire.valid
  ) else begin
    $error("retire.valid high while halted");
    n_fail = n_fail + 1;
  end

  // x0 never reported as written
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (!rst_n) (retire.rd == 5'd0) |-> !retire.we
  ) else begin
    $error("retire.we high with rd x0");
    n_fail = n_fail + 1;
  end

  a_pc_frozen: assert property (
    @(posedge clk) disable iff (!rst_n) halt |=> $stable(pc)
  ) else begin
    $error("pc moved while halted");
    n_fail = n_fail + 1;
  end

  a_no_retire_reset: assert property (
    @(posedge clk) !rst_n |-> !retire.valid
  ) else begin
    $error("retire.valid high during reset");
    n_fail = n_fail + 1;
  end

endmodule

bind rv_core rv_core_chk i_rv_core_chk (
  .clk    (clk),
  .rst_n  (rst_n),
  .pc     (pc),
  .retire (retire),
  .halt   (halt)
);

`default_nettype wire

/* tb_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_core import rv_pkg::*; ();

  logic            clk;
  logic            rst_n;
  logic [31:0]     inst;
  logic [xlen-1:0] pc;
  retire_t         retire;
  logic            halt;
  logic            exit_code;

  logic [31:0]     prog [$];
  logic [xlen-1:0] ref_regs [32];
  logic [xlen-1:0] ref_mem [dmem_words];
  logic [xlen-1:0] ref_pc;
  logic            ref_halt;
  logic            ref_code;
  logic            checking;
  integer          seed = 66;
  int              n_checks;
  int              n_errors;
  longint          run_start;
  longint          limit_ns;

  rv_core i_rv_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst      (inst),
    .pc        (pc),
    .retire    (retire),
    .halt      (halt),
    .exit_code (exit_code)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // instruction memory returns an illegal word outside the program
  function automatic logic [31:0] fetch_word(input logic [xlen-1:0] addr);
    logic [xlen-1:0] off;
    if ($isunknown(addr)) return 32'h0;
    off = addr - reset_vector;
    if (off[1:0] != 2'b00 || (off >> 2) >= prog.size()) return 32'h0;
    return prog[off >> 2];
  endfunction

  function automatic logic [xlen-1:0] mem_word(input logic [xlen-1:0] addr);
    logic [xlen-1:0] off;
    off = addr - dmem_base;
    if (off < dmem_words * 8) return ref_mem[off[9:3]];
    return '0;
  endfunction

  function automatic retire_t rv_ref_step(input logic [31:0] w, output logic stop,
                                          output logic code);
    retire_t         r;
    logic [4:0]      rd;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] res;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] word;
    logic [31:0]     half;
    logic            wr;
    rd = w[11:7];
    a = ref_regs[w[19:15]];
    b = ref_regs[w[24:20]];
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
    imm_u = {{32{w[31]}}, w[31:12], 12'b0};
    res = '0;
    wr = 1'b1;
    stop = 1'b0;
    code = 1'b0;
    r.next_pc = ref_pc + 64'd4;
    case (w[6:0])
      7'h33: res = w[30] ? a - b : a + b;
      7'h13: begin
        case (w[14:12])
          3'b000: res = a + imm_i;
          3'b001: res = a << w[25:20];
          3'b011: res = (a < imm_i) ? 64'd1 : 64'd0;
          3'b100: res = a ^ imm_i;
          default: res = a & imm_i;
        endcase
      end
      7'h1b: begin
        res = a + imm_i;
        res = {{32{res[31]}}, res[31:0]};
      end
      7'h37: res = imm_u;
      7'h17: res = ref_pc + imm_u;
      7'h6f: begin
        res = ref_pc + 64'd4;
        r.next_pc = ref_pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      7'h67: begin
        res = ref_pc + 64'd4;
        r.next_pc = (a + imm_i) & ~64'd1;
      end
      7'h63: begin
        wr = 1'b0;
        // beq takes on equal and bne on unequal
        if ((a == b) == (w[14:12] == 3'b000)) begin
          r.next_pc = ref_pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      7'h03: begin
        addr = a + imm_i;
        word = mem_word(addr);
        half = addr[2] ? word[63:32] : word[31:0];
        case (w[14:12])
          3'b010: res = {{32{half[31]}}, half};
          3'b100: res = {56'b0, word[8*addr[2:0] +: 8]};
          default: res = word;
        endcase
      end
      7'h23: begin
        wr = 1'b0;
        addr = a + imm_s;
        if (addr - dmem_base < dmem_words * 8) begin
          word = mem_word(addr);
          case (w[14:12])
            3'b000: word[8*addr[2:0] +: 8] = b[7:0];
            3'b001: word[16*addr[2:1] +: 16] = b[15:0];
            default: word = b;
          endcase
          ref_mem[addr[9:3]] = word;
        end
      end
      default: begin
        // ebreak reports a0 and any other word is illegal
        wr = 1'b0;
        stop = 1'b1;
        code = (w != 32'h0010_0073) || (ref_regs[10] != '0);
      end
    endcase
    r.valid = 1'b1;
    r.pc = ref_pc;
    r.rd = rd;
    r.we = wr && (rd != 5'd0);
    r.wdata = res;
    if (r.we) ref_regs[rd] = res;
    if (!stop) ref_pc = r.next_pc;
    return r;
  endfunction

  task automatic check_field(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("error at %0t: %s expected %h got %h", $time, name, want, got);
    end
  endtask

  task automatic load_reg(input logic [4:0] rd);
    logic [31:0] r;
    r = rnd();
    prog.push_back(enc_u(r[31:12], rd, 7'h37));
    prog.push_back(enc_i(r[11:0], rd, 3'b000, rd, 7'h13));
  endtask

  task automatic random_alu_op();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    r = rnd();
    rd = {1'b0, r[3:0]};
    rs1 = {1'b0, r[7:4]};
    rs2 = {1'b0, r[11:8]};
    case (r[14:12])
      3'd0: prog.push_back(enc_r(7'h00, rs2, rs1, 3'b000, rd));
      3'd1: prog.push_back(enc_r(7'h20, rs2, rs1, 3'b000, rd));
      3'd2: prog.push_back(enc_i(r[31:20], rs1, 3'b000, rd, 7'h13));
      3'd3: prog.push_back(enc_i(r[31:20], rs1, 3'b000, rd, 7'h1b));
      3'd4: prog.push_back(enc_i({6'b0, r[25:20]}, rs1, 3'b001, rd, 7'h13));
      3'd5: prog.push_back(enc_i(r[31:20], rs1, 3'b011, rd, 7'h13));
      3'd6: prog.push_back(enc_i(r[31:20], rs1, 3'b111, rd, 7'h13));
      default: prog.push_back(enc_i(r[31:20], rs1, 3'b100, rd, 7'h13));
    endcase
  endtask

  // base in x20 with store data in x22 and x23 and loads into x24 to x26
  task automatic byte_lanes(input logic [11:0] off);
    prog.push_back(enc_s(off, 5'd22, 5'd20, 3'b011));
    for (int i = 0; i < 8; i++) begin
      prog.push_back(enc_s(off + i, 5'd23, 5'd20, 3'b000));
      prog.push_back(enc_i(off, 5'd20, 3'b011, 5'd24, 7'h03));
      prog.push_back(enc_i(off + 4, 5'd20, 3'b010, 5'd25, 7'h03));
      prog.push_back(enc_i(off + i, 5'd20, 3'b100, 5'd26, 7'h03));
    end
  endtask

  task automatic half_lanes(input logic [11:0] off);
    prog.push_back(enc_s(off, 5'd22, 5'd20, 3'b011));
    for (int h = 0; h < 4; h++) begin
      prog.push_back(enc_s(off + 2 * h, 5'd23, 5'd20, 3'b001));
      prog.push_back(enc_i(off, 5'd20, 3'b011, 5'd24, 7'h03));
      prog.push_back(enc_i(off, 5'd20, 3'b010, 5'd25, 7'h03));
      prog.push_back(enc_i(off + 4, 5'd20, 3'b010, 5'd25, 7'h03));
      prog.push_back(enc_i(off + 2 * h + 1, 5'd20, 3'b100, 5'd26, 7'h03));
    end
  endtask

  task automatic build_main();
    logic [31:0] r;
    prog.delete();
    for (int i = 1; i < 16; i++) load_reg(i);
    repeat (40) random_alu_op();
    prog.push_back(enc_i(12'd7, 5'd1, 3'b000, 5'd0, 7'h13));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
    // upper immediates and jumps over fillers that bump x1 or x2
    r = rnd();
    prog.push_back(enc_u(r[19:0], 5'd5, 7'h37));
    prog.push_back(enc_u(r[31:12], 5'd6, 7'h17));
    prog.push_back(enc_j(21'd8, 5'd7));
    prog.push_back(enc_i(12'd1, 5'd1, 3'b000, 5'd1, 7'h13));
    prog.push_back(enc_u(20'd0, 5'd6, 7'h17));
    prog.push_back(enc_i(12'd13, 5'd6, 3'b000, 5'd7, 7'h67));
    prog.push_back(enc_i(12'd1, 5'd2, 3'b000, 5'd2, 7'h13));
    // branches on x11 == x12 and x11 != x13
    load_reg(11);
    prog.push_back(enc_i(12'd0, 5'd11, 3'b000, 5'd12, 7'h13));
    load_reg(13);
    for (int k = 0; k < 4; k++) begin
      prog.push_back(enc_b(13'd8, k[0] ? 5'd13 : 5'd12, 5'd11, k[1] ? 3'b001 : 3'b000));
      prog.push_back(enc_i(12'd1, 5'd3, 3'b000, 5'd3, 7'h13));
    end
    prog.push_back(enc_i(12'd1, 5'd0, 3'b000, 5'd20, 7'h13));
    prog.push_back(enc_i(12'd31, 5'd20, 3'b001, 5'd20, 7'h13));
    prog.push_back(enc_u(20'd1, 5'd21, 7'h37));
    prog.push_back(enc_r(7'h00, 5'd21, 5'd20, 3'b000, 5'd20));
    load_reg(22);
    prog.push_back(enc_i(12'd32, 5'd22, 3'b001, 5'd22, 7'h13));
    prog.push_back(enc_i(r[11:0], 5'd22, 3'b100, 5'd22, 7'h13));
    load_reg(23);
    prog.push_back(enc_i(-12'sd5, 5'd0, 3'b000, 5'd27, 7'h13));
    r = rnd();
    byte_lanes({r[5:0] % 6'd40, 3'b000});
    half_lanes({7'd40 + r[11:6] % 7'd40, 3'b000});
    // negative upper half for lw
    prog.push_back(enc_s(12'd1000, 5'd27, 5'd20, 3'b011));
    prog.push_back(enc_i(12'd1004, 5'd20, 3'b010, 5'd25, 7'h03));
    prog.push_back(enc_i(12'd1000, 5'd20, 3'b010, 5'd25, 7'h03));
    prog.push_back(enc_i(12'd1007, 5'd20, 3'b100, 5'd26, 7'h03));
    prog.push_back(enc_i(-12'sd8, 5'd20, 3'b011, 5'd24, 7'h03));
    prog.push_back(enc_i(12'd0, 5'd0, 3'b000, 5'd10, 7'h13));
    prog.push_back(32'h0010_0073);
  endtask

  task automatic build_halt_run(input logic illegal_end);
    prog.delete();
    load_reg(1);
    load_reg(2);
    repeat (6) random_alu_op();
    prog.push_back(enc_i(illegal_end ? 12'd0 : 12'd5, 5'd0, 3'b000, 5'd10, 7'h13));
    prog.push_back(illegal_end ? 32'h0000_0000 : 32'h0010_0073);
  endtask

  task automatic run_program(input logic exp_exit);
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    ref_pc = reset_vector;
    ref_halt = 1'b0;
    ref_code = 1'b0;
    run_start = $time;
    limit_ns = (prog.size() + 20) * 10 + 40;
    @(posedge clk);
    #1 rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    checking = 1'b1;
    while (halt !== 1'b1) @(posedge clk);
    repeat (3) @(posedge clk);
    #1 checking = 1'b0;
    check_field("exit_code", exit_code, exp_exit);
  endtask

  always @(posedge clk) begin
    #1 inst = fetch_word(pc);
  end

  always @(posedge clk) begin
    retire_t want;
    logic    stop;
    logic    code;
    if (checking) begin
      if (!ref_halt) begin
        want = rv_ref_step(fetch_word(ref_pc), stop, code);
        check_field("halt", halt, 1'b0);
        check_field("valid", retire.valid, want.valid);
        check_field("pc", retire.pc, want.pc);
        check_field("rd", retire.rd, want.rd);
        check_field("we", retire.we, want.we);
        if (want.we) check_field("wdata", retire.wdata, want.wdata);
        check_field("next_pc", retire.next_pc, want.next_pc);
        ref_halt = stop;
        ref_code = code;
      end else begin
        // frozen after halt
        check_field("halt", halt, 1'b1);
        check_field("valid", retire.valid, 1'b0);
        check_field("exit_code", exit_code, ref_code);
        check_field("pc", pc, ref_pc);
      end
    end
  end

  always @(posedge clk) begin
    if (checking && ($time - run_start) > limit_ns) begin
      $display("timeout: the core did not halt within %0d ns", limit_ns);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    rst_n = 1'b0;
    inst = 32'h0;
    checking = 1'b0;
    n_checks = 0;
    n_errors = 0;
    for (int i = 0; i < dmem_words; i++) ref_mem[i] = '0;
    build_main();
    run_program(1'b0);
    build_halt_run(1'b0);
    run_program(1'b1);
    build_halt_run(1'b1);
    run_program(1'b1);
    n_errors = n_errors + i_rv_core.i_rv_core_chk.n_fail;
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
rv_pkg.sv
rv_alu.sv
rv_lsu.sv
rv_regfile.sv
rv_idu.sv
rv_exu.sv
rv_core.sv
tb_core_chk.sv
tb_core.sv

/* Bender.yml */
package:
  name: rv_core_slice

sources:
  - rv_pkg.sv
  - rv_alu.sv
  - rv_lsu.sv
  - rv_regfile.sv
  - rv_idu.sv
  - rv_exu.sv
  - rv_core.sv
  - target: test
    files:
      - tb_core_chk.sv
      - tb_core.sv
